// ==== vlog.f ====
hw/drbg_pkg.sv
hw/cmd_fifo.sv
hw/gen_block_counter.sv
hw/genbits_buffer.sv
hw/cmd_stage_ctrl.sv
hw/cmd_stage_top.sv
test/tb_cmd_stage.sv

// ==== Makefile ====
# Verilator simulation of the DRBG command stage.
# Override on the command line, for example: make sim TOP=tb_cmd_stage

VERILATOR ?= verilator
TOP       ?= tb_cmd_stage
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_cmd_stage.sv ====
// --------------------------------------------------------------------------
// Testbench for the DRBG command stage.
// Random commands against a model arbiter, a model core and a scoreboard.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_cmd_stage;
  import drbg_pkg::*;

  localparam int NumCmds      = 12;
  localparam int CmdFifoDepth = 16;
  localparam int StateIdWidth = 4;
  localparam int ClkPeriod    = 100;
  // Worst case per command covers random grant, ack and ready delays.
  localparam int MaxCycles    = (2 * NumCmds + 4) * 400;

  logic clk_i, rst_ni, enable_i, cmd_vld_i, cmd_rdy_o;
  cmd_word_t cmd_bus_i, arb_bus_o;
  logic [StateIdWidth-1:0] shid_i;
  logic arb_req_o, arb_sop_o, arb_mop_o, arb_eop_o, arb_gnt_i;
  logic ack_i, ack_sts_i, ack_o, ack_sts_o;
  logic genbits_vld_i, genbits_fips_i, genbits_vld_o, genbits_rdy_i, genbits_fips_o;
  genbits_t genbits_i, genbits_o;
  fifo_err_t cmd_fifo_err_o, genbits_err_o;
  logic gen_cnt_err_o, sm_err_o;

  // Scoreboard state.
  logic [34:0]  exp_beat[$];
  logic [128:0] exp_blk[$];
  logic         exp_sts[$];
  int           cmd_pkts[$];
  int           cur_left, acks_expected, acks_seen, eop_cnt;
  logic         hold_rdy;
  logic [31:0]  lfsr_q;

  cmd_stage_top #(
    .CmdFifoDepth (CmdFifoDepth),
    .StateIdWidth (StateIdWidth)
  ) UUT (.*);

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // Galois LFSR stepped once per bit.
  function automatic logic next_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) lfsr_q = lfsr_q ^ 32'h80200003;
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
    return v;
  endfunction

  task automatic stop_with_failure();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic compare_values(input logic [159:0] got, input logic [159:0] want,
                                input string what);
    if (got !== want) begin
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, want);
      stop_with_failure();
    end
  endtask

  // Each word takes two cycles and waits for room in the FIFO.
  task automatic push_word(input cmd_word_t w);
    @(negedge clk_i);
    while (!cmd_rdy_o) @(negedge clk_i);
    @(posedge clk_i);
    cmd_vld_i <= 1'b1;
    cmd_bus_i <= w;
    @(posedge clk_i);
    cmd_vld_i <= 1'b0;
  endtask

  task automatic queue_command(input logic [2:0] op, input int clen, input int glen,
                               input logic [3:0] flags, input logic [7:0] top);
    cmd_word_t hdr;
    cmd_word_t data[4];
    int        pkts;
    hdr = {top, 12'(glen), flags, 4'(clen), 1'b0, op};
    exp_beat.push_back({1'b1, 1'b0, clen == 0, 15'b0, glen == 1, shid_i, hdr[11:0]});
    for (int i = 0; i < clen; i++) begin
      data[i] = rand_bits(32);
      exp_beat.push_back({1'b0, 1'b1, i == clen - 1, data[i]});
    end
    // Header replays for the remaining generate blocks.
    for (int k = 2; k <= glen; k++) begin
      exp_beat.push_back({1'b1, 1'b0, 1'b1, 15'b0, k == glen, shid_i, hdr[11:0]});
    end
    pkts = (glen == 0) ? 1 : glen;
    cmd_pkts.push_back(pkts * 2 + int'(op == GEN));
    push_word(hdr);
    for (int i = 0; i < clen; i++) push_word(data[i]);
  endtask

  task automatic random_command();
    logic [2:0] op;
    int         clen;
    int         glen;
    op   = 3'(rand_bits(3) % 5 + 1);
    clen = rand_bits(2);
    glen = (op == GEN) ? rand_bits(2) + 1 : 0;
    acks_expected++;
    queue_command(op, clen, glen, rand_bits(4), rand_bits(8));
  endtask

  task automatic wait_drain();
    do @(negedge clk_i); while (acks_seen != acks_expected || exp_blk.size() != 0);
    repeat (4) @(negedge clk_i);
  endtask

  // Scoreboard sampled at the falling edge.
  always @(negedge clk_i) begin
    if (rst_ni) begin
      compare_values(cmd_fifo_err_o, '0, "command FIFO error");
      compare_values(genbits_err_o, '0, "genbits buffer error");
      compare_values(gen_cnt_err_o, 1'b0, "block counter error");
      compare_values(sm_err_o, 1'b0, "state machine error");
      if (arb_sop_o || arb_mop_o) begin
        if (exp_beat.size() == 0) begin
          $display("Arbiter beat at %0t with no beat expected", $time);
          stop_with_failure();
        end
        compare_values({arb_sop_o, arb_mop_o, arb_eop_o, arb_bus_o}, exp_beat.pop_front(),
                       "arbiter beat {sop, mop, eop, bus}");
        if (arb_eop_o) eop_cnt++;
      end
      if (genbits_vld_o && genbits_rdy_i) begin
        if (exp_blk.size() == 0) begin
          $display("Generated block at %0t with no block expected", $time);
          stop_with_failure();
        end
        compare_values({genbits_fips_o, genbits_o}, exp_blk.pop_front(), "genbits output");
      end
      if (ack_o) begin
        if (exp_sts.size() == 0) begin
          $display("Acknowledge at %0t with no command finished by the core", $time);
          stop_with_failure();
        end
        compare_values(ack_sts_o, exp_sts.pop_front(), "acknowledge status");
        acks_seen++;
      end
    end
  end

  // Arbiter model.
  initial begin
    forever begin
      @(negedge clk_i);
      if (rst_ni && arb_req_o) begin
        repeat (rand_bits(2)) @(posedge clk_i);
        @(posedge clk_i);
        arb_gnt_i <= 1'b1;
        @(posedge clk_i);
        arb_gnt_i <= 1'b0;
      end
    end
  end

  // Core model with one ack per packet and a block with each generate ack.
  initial begin
    int       eops_done;
    int       info;
    logic     cur_gen;
    logic     sts;
    logic     fips;
    genbits_t blk;
    eops_done = 0;
    cur_gen   = 1'b0;
    forever begin
      @(posedge clk_i);
      if (eop_cnt != eops_done) begin
        eops_done++;
        repeat (rand_bits(3)) @(posedge clk_i);
        do @(negedge clk_i); while (genbits_vld_o);
        if (cur_left == 0) begin
          if (cmd_pkts.size() == 0) begin
            $display("Packet end at %0t with no command in flight", $time);
            stop_with_failure();
          end
          info     = cmd_pkts.pop_front();
          cur_left = info / 2;
          cur_gen  = info[0];
        end
        cur_left--;
        sts  = next_bit();
        fips = next_bit();
        blk  = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
        if (cur_left == 0) exp_sts.push_back(sts);
        if (cur_gen) exp_blk.push_back({fips, blk});
        @(posedge clk_i);
        ack_i          <= 1'b1;
        ack_sts_i      <= sts;
        genbits_vld_i  <= cur_gen;
        genbits_i      <= blk;
        genbits_fips_i <= fips;
        @(posedge clk_i);
        ack_i         <= 1'b0;
        genbits_vld_i <= 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin
    genbits_rdy_i <= hold_rdy ? 1'b0 : next_bit();
  end

  initial begin
    #(longint'(MaxCycles) * ClkPeriod);
    $display("Timeout: the run did not finish within %0d clock cycles", MaxCycles);
    stop_with_failure();
  end

  initial begin
    lfsr_q = 32'h6877;
    {rst_ni, cmd_vld_i, arb_gnt_i, ack_i, ack_sts_i} = '0;
    {genbits_vld_i, genbits_fips_i, genbits_rdy_i} = '0;
    cmd_bus_i = '0;
    genbits_i = '0;
    enable_i  = 1'b1;
    shid_i    = 4'h9;
    hold_rdy  = 1'b0;
    {cur_left, acks_expected, acks_seen, eop_cnt} = '0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    repeat (NumCmds) random_command();
    wait_drain();

    // Back-pressure stalls a three-block generate after its first block.
    hold_rdy = 1'b1;
    queue_command(GEN, 0, 3, 4'h5, 8'h3C);
    do @(negedge clk_i); while (!genbits_vld_o);
    repeat (20) begin
      @(negedge clk_i);
      compare_values(arb_req_o, 1'b0, "arbiter request under back-pressure");
    end
    repeat (CmdFifoDepth) push_word(rand_bits(32));
    @(negedge clk_i);
    compare_values(cmd_rdy_o, 1'b0, "command ready with a full FIFO");

    // Enable pulse drops the stalled command and the queued words.
    @(posedge clk_i);
    enable_i <= 1'b0;
    exp_beat.delete();
    exp_blk.delete();
    exp_sts.delete();
    cmd_pkts.delete();
    cur_left = 0;
    @(posedge clk_i);
    enable_i <= 1'b1;
    @(negedge clk_i);
    compare_values(cmd_rdy_o, 1'b1, "command ready after enable pulse");
    // The dropped generate must not request the arbiter again.
    repeat (4) begin
      compare_values(arb_req_o, 1'b0, "arbiter request after enable pulse");
      compare_values(genbits_vld_o, 1'b0, "genbits valid after enable pulse");
      @(negedge clk_i);
    end
    hold_rdy = 1'b0;

    repeat (NumCmds) random_command();
    wait_drain();

    if (exp_beat.size() + exp_blk.size() + exp_sts.size() + cmd_pkts.size() == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Expected beats, blocks or acknowledges were never seen");
      stop_with_failure();
    end
  end

endmodule

// ==== hw/cmd_stage_top.sv ====
// --------------------------------------------------------------------------
// DRBG command stage top level.
// Joins the controller with the command FIFO, block counter and buffer.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module cmd_stage_top import drbg_pkg::*; #(
  parameter int unsigned CmdFifoDepth = 16,
  parameter int unsigned StateIdWidth = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    enable_i,
  // Application commands.
  input  logic                    cmd_vld_i,
  input  cmd_word_t               cmd_bus_i,
  input  logic [StateIdWidth-1:0] shid_i,
  output logic                    cmd_rdy_o,
  // Arbiter packets.
  output logic                    arb_req_o,
  output logic                    arb_sop_o,
  output logic                    arb_mop_o,
  output logic                    arb_eop_o,
  input  logic                    arb_gnt_i,
  output cmd_word_t               arb_bus_o,
  // Core acknowledge.
  input  logic                    ack_i,
  input  logic                    ack_sts_i,
  output logic                    ack_o,
  output logic                    ack_sts_o,
  // Generated blocks.
  input  logic                    genbits_vld_i,
  input  genbits_t                genbits_i,
  input  logic                    genbits_fips_i,
  output logic                    genbits_vld_o,
  input  logic                    genbits_rdy_i,
  output genbits_t                genbits_o,
  output logic                    genbits_fips_o,
  // Errors.
  output fifo_err_t               cmd_fifo_err_o,
  output fifo_err_t               genbits_err_o,
  output logic                    gen_cnt_err_o,
  output logic                    sm_err_o
);

  cmd_word_t                     fifo_rdata;
  logic [$clog2(CmdFifoDepth):0] fifo_depth;
  logic                          fifo_full;
  logic                          fifo_pop;
  logic                          gen_set;
  glen_t                         gen_set_cnt;
  logic                          gen_dec;
  glen_t                         gen_cnt;
  logic                          buf_full;

  assign cmd_rdy_o = !fifo_full;

  cmd_fifo #(
    .Width (CmdWidth),
    .Depth (CmdFifoDepth)
  ) u_cmd_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clr_i    (!enable_i),
    .wvalid_i (cmd_vld_i),
    .wdata_i  (cmd_bus_i),
    .rready_i (fifo_pop),
    .rvalid_o (),
    .rdata_o  (fifo_rdata),
    .full_o   (fifo_full),
    .depth_o  (fifo_depth),
    .err_o    (cmd_fifo_err_o)
  );

  gen_block_counter u_gen_block_counter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .clr_i     (!enable_i),
    .set_i     (gen_set),
    .set_cnt_i (gen_set_cnt),
    .dec_i     (gen_dec),
    .cnt_o     (gen_cnt),
    .err_o     (gen_cnt_err_o)
  );

  genbits_buffer u_genbits_buffer (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clr_i    (!enable_i),
    .push_i   (genbits_vld_i),
    .bits_i   (genbits_i),
    .fips_i   (genbits_fips_i),
    .rdy_i    (genbits_rdy_i),
    .enable_i (enable_i),
    .vld_o    (genbits_vld_o),
    .bits_o   (genbits_o),
    .fips_o   (genbits_fips_o),
    .full_o   (buf_full),
    .err_o    (genbits_err_o)
  );

  cmd_stage_ctrl #(
    .CmdFifoDepth (CmdFifoDepth),
    .StateIdWidth (StateIdWidth)
  ) u_cmd_stage_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .enable_i      (enable_i),
    .shid_i        (shid_i),
    .fifo_rdata_i  (fifo_rdata),
    .fifo_depth_i  (fifo_depth),
    .ack_i         (ack_i),
    .ack_sts_i     (ack_sts_i),
    .arb_gnt_i     (arb_gnt_i),
    .gen_cnt_i     (gen_cnt),
    .gen_cnt_err_i (gen_cnt_err_o),
    .buf_full_i    (buf_full),
    .fifo_pop_o    (fifo_pop),
    .gen_set_o     (gen_set),
    .gen_set_cnt_o (gen_set_cnt),
    .gen_dec_o     (gen_dec),
    .arb_req_o     (arb_req_o),
    .arb_sop_o     (arb_sop_o),
    .arb_mop_o     (arb_mop_o),
    .arb_eop_o     (arb_eop_o),
    .arb_bus_o     (arb_bus_o),
    .ack_o         (ack_o),
    .ack_sts_o     (ack_sts_o),
    .sm_err_o      (sm_err_o)
  );

endmodule

// ==== hw/cmd_stage_ctrl.sv ====
// --------------------------------------------------------------------------
// Command stage controller.
// Sends queued commands as arbiter packets, replays generate headers and
// returns the final acknowledge.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module cmd_stage_ctrl import drbg_pkg::*; #(
  parameter int unsigned CmdFifoDepth = 16,
  parameter int unsigned StateIdWidth = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          enable_i,
  input  logic [StateIdWidth-1:0]       shid_i,
  input  cmd_word_t                     fifo_rdata_i,
  input  logic [$clog2(CmdFifoDepth):0] fifo_depth_i,
  input  logic                          ack_i,
  input  logic                          ack_sts_i,
  input  logic                          arb_gnt_i,
  input  glen_t                         gen_cnt_i,
  input  logic                          gen_cnt_err_i,
  input  logic                          buf_full_i,
  output logic                          fifo_pop_o,
  output logic                          gen_set_o,
  output glen_t                         gen_set_cnt_o,
  output logic                          gen_dec_o,
  output logic                          arb_req_o,
  output logic                          arb_sop_o,
  output logic                          arb_mop_o,
  output logic                          arb_eop_o,
  output cmd_word_t                     arb_bus_o,
  output logic                          ack_o,
  output logic                          ack_sts_o,
  output logic                          sm_err_o
);

  localparam int unsigned PadWidth = CmdWidth - 1 - StateIdWidth - CmdKeepWidth;

  // Sparse encoding, minimum Hamming distance of three.
  typedef enum logic [7:0] {
    Idle      = 8'b00011011,
    ArbGnt    = 8'b11110101,
    SendSop   = 8'b00011100,
    SendMop   = 8'b00000001,
    GenCmdChk = 8'b01010110,
    CmdAck    = 8'b10001101,
    GenReq    = 8'b11000000,
    GenArbGnt = 8'b11111110,
    GenSop    = 8'b10110010,
    Error     = 8'b10111001
  } state_e;

  state_e    state_d;
  state_e    state_q;
  logic      fifo_empty;
  clen_t     cmd_clen;
  logic      cmd_is_gen;
  logic      first_req;
  logic      replay_req;
  logic      glast;
  logic      clen_dec;
  logic      final_ack;
  logic      sts_capture;
  clen_t     clen_q;
  logic      gen_flag_q;
  cmd_keep_t gen_cmd_q;
  logic      ack_q;
  logic      ack_sts_q;

  assign fifo_empty = (fifo_depth_i == '0);
  assign cmd_clen   = fifo_rdata_i[ClenLsb +: ClenWidth];
  assign cmd_is_gen = (acmd_e'(fifo_rdata_i[OpWidth-1:0]) == GEN);

  assign gen_set_o     = first_req;
  assign gen_set_cnt_o = fifo_rdata_i[GlenLsb +: GlenWidth];

  // --------------------------------------------------------------------------
  // Packet bus.
  // --------------------------------------------------------------------------

  // Header beat is pad, glast, shid, then the low command bits.
  assign arb_bus_o =
      replay_req ? {{PadWidth{1'b0}}, glast, shid_i, gen_cmd_q} :
      first_req  ? {{PadWidth{1'b0}}, glast, shid_i, fifo_rdata_i[CmdKeepWidth-1:0]} :
      arb_mop_o  ? fifo_rdata_i :
      '0;

  // Command fields.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clen_q     <= '0;
      gen_flag_q <= 1'b0;
      ack_q      <= 1'b0;
      ack_sts_q  <= 1'b0;
    end else if (!enable_i) begin
      clen_q     <= '0;
      gen_flag_q <= 1'b0;
      ack_q      <= 1'b0;
      ack_sts_q  <= 1'b0;
    end else begin
      if (first_req) begin
        clen_q     <= cmd_clen;
        gen_flag_q <= cmd_is_gen;
      end else if (clen_dec) begin
        clen_q <= clen_q - 1'b1;
      end
      ack_q <= final_ack;
      if (sts_capture) begin
        ack_sts_q <= ack_sts_i;
      end
    end
  end

  // Header kept for the later generate requests.
  always_ff @(posedge clk_i) begin
    if (first_req) begin
      gen_cmd_q <= fifo_rdata_i[CmdKeepWidth-1:0];
    end
  end

  assign ack_o     = ack_q;
  assign ack_sts_o = ack_sts_q;

  // --------------------------------------------------------------------------
  // State machine.
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d     = state_q;
    fifo_pop_o  = 1'b0;
    gen_dec_o   = 1'b0;
    arb_req_o   = 1'b0;
    arb_sop_o   = 1'b0;
    arb_mop_o   = 1'b0;
    arb_eop_o   = 1'b0;
    sm_err_o    = 1'b0;
    first_req   = 1'b0;
    replay_req  = 1'b0;
    glast       = 1'b0;
    clen_dec    = 1'b0;
    final_ack   = 1'b0;
    sts_capture = 1'b0;

    if (state_q == Error) begin
      // Held here until reset.
      sm_err_o = 1'b1;
    end else if (gen_cnt_err_i) begin
      state_d = Error;
    end else if (!enable_i && state_q inside {Idle, ArbGnt, SendSop, SendMop, GenCmdChk,
                                              CmdAck, GenReq, GenArbGnt, GenSop}) begin
      state_d = Idle;
    end else begin
      unique case (state_q)
        Idle: begin
          if (!fifo_empty) begin
            state_d = ArbGnt;
          end
        end
        ArbGnt: begin
          arb_req_o = 1'b1;
          if (arb_gnt_i) begin
            state_d = SendSop;
          end
        end
        SendSop: begin
          first_req  = 1'b1;
          arb_sop_o  = 1'b1;
          fifo_pop_o = 1'b1;
          glast      = (fifo_rdata_i[GlenLsb +: GlenWidth] == glen_t'(1));
          if (cmd_clen == '0) begin
            arb_eop_o = 1'b1;
            state_d   = GenCmdChk;
          end else begin
            state_d = SendMop;
          end
        end
        SendMop: begin
          // Stall while the next data word is missing.
          if (!fifo_empty) begin
            fifo_pop_o = 1'b1;
            clen_dec   = 1'b1;
            arb_mop_o  = 1'b1;
            if (clen_q == clen_t'(1)) begin
              arb_eop_o = 1'b1;
              state_d   = GenCmdChk;
            end
          end
        end
        GenCmdChk: begin
          gen_dec_o = gen_flag_q;
          state_d   = CmdAck;
        end
        CmdAck: begin
          if (ack_i) begin
            // Status only counts on the last core ack.
            sts_capture = !gen_flag_q || (gen_cnt_i == '0);
            state_d     = GenReq;
          end
        end
        GenReq: begin
          if (!gen_flag_q) begin
            final_ack = 1'b1;
            state_d   = Idle;
          end else if (!buf_full_i) begin
            if (gen_cnt_i == '0) begin
              final_ack = 1'b1;
              state_d   = Idle;
            end else begin
              state_d = GenArbGnt;
            end
          end
        end
        GenArbGnt: begin
          arb_req_o = 1'b1;
          if (arb_gnt_i) begin
            state_d = GenSop;
          end
        end
        GenSop: begin
          replay_req = 1'b1;
          arb_sop_o  = 1'b1;
          arb_eop_o  = 1'b1;
          glast      = (gen_cnt_i == glen_t'(1));
          state_d    = GenCmdChk;
        end
        default: begin
          state_d  = Error;
          sm_err_o = 1'b1;
        end
      endcase
    end
  end

  ErrorStable_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == Error) |=> (state_q == Error));

  ErrorOutput_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == Error) |-> sm_err_o);

endmodule

// ==== hw/genbits_buffer.sv ====
// --------------------------------------------------------------------------
// One-entry buffer for a generated block and its FIPS flag.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module genbits_buffer import drbg_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clr_i,
  input  logic      push_i,
  input  genbits_t  bits_i,
  input  logic      fips_i,
  input  logic      rdy_i,
  input  logic      enable_i,
  output logic      vld_o,
  output genbits_t  bits_o,
  output logic      fips_o,
  output logic      full_o,
  output fifo_err_t err_o
);

  genbits_t bits_q;
  logic     fips_q;
  logic     full_q;
  logic     push;
  logic     pop;

  assign push  = enable_i && push_i;
  assign vld_o = enable_i && full_q;
  assign pop   = vld_o && rdy_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (clr_i) begin
      full_q <= 1'b0;
    end else if (push) begin
      full_q <= 1'b1;
    end else if (pop) begin
      full_q <= 1'b0;
    end
  end

  // Last block stays on the output after it is taken.
  always_ff @(posedge clk_i) begin
    if (push) begin
      bits_q <= bits_i;
      fips_q <= fips_i;
    end
  end

  assign bits_o = bits_q;
  assign fips_o = fips_q;
  assign full_o = full_q;

  // A single entry is never full and empty at once.
  assign err_o = {push && full_q, pop && !full_q, 1'b0};

endmodule

// ==== hw/gen_block_counter.sv ====
// --------------------------------------------------------------------------
// Redundant down-counter of the generate blocks still to request.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module gen_block_counter import drbg_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clr_i,
  input  logic  set_i,
  input  glen_t set_cnt_i,
  input  logic  dec_i,
  output glen_t cnt_o,
  output logic  err_o
);

  glen_t down_q;
  glen_t up_inv_q;
  glen_t up_cnt;

  // Up copy kept inverted, so both registers rest at all ones.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      down_q   <= '1;
      up_inv_q <= '1;
    end else if (clr_i) begin
      down_q   <= '1;
      up_inv_q <= '1;
    end else if (set_i) begin
      down_q   <= set_cnt_i;
      up_inv_q <= ~(~set_cnt_i);
    end else if (dec_i) begin
      down_q   <= down_q - 1'b1;
      up_inv_q <= ~(up_cnt + 1'b1);
    end
  end

  assign up_cnt = ~up_inv_q;
  assign cnt_o  = down_q;

  // Both copies together always sum to all ones.
  assign err_o = (glen_t'(down_q + up_cnt) != '1);

  NoDecAtZero_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dec_i |-> (down_q != '0));

endmodule

// ==== hw/cmd_fifo.sv ====
// --------------------------------------------------------------------------
// Synchronous command FIFO.
// Circular buffer with clear, fill depth and an error vector.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module cmd_fifo import drbg_pkg::*; #(
  parameter int unsigned Width = CmdWidth,
  parameter int unsigned Depth = 16
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clr_i,
  input  logic                   wvalid_i,
  input  cmd_word_t              wdata_i,
  input  logic                   rready_i,
  output logic                   rvalid_o,
  output cmd_word_t              rdata_o,
  output logic                   full_o,
  output logic [$clog2(Depth):0] depth_o,
  output fifo_err_t              err_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth) + 1;

  logic [Width-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wptr_q;
  logic [PtrW-1:0]  rptr_q;
  logic [CntW-1:0]  cnt_q;
  logic             empty;
  logic             push;
  logic             pop;

  // Pointer step with wrap at the last entry.
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty    = (cnt_q == '0);
  assign full_o   = (cnt_q == CntW'(Depth));
  assign rvalid_o = !empty;
  assign depth_o  = cnt_q;

  assign push = wvalid_i && !full_o;
  assign pop  = rready_i && !empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else if (clr_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) begin
        wptr_q <= ptr_inc(wptr_q);
      end
      if (pop) begin
        rptr_q <= ptr_inc(rptr_q);
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Storage.
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i[Width-1:0];
    end
  end

  // Head word is visible without a pop.
  assign rdata_o = CmdWidth'(mem_q[rptr_q]);

  assign err_o = {wvalid_i && full_o, rready_i && empty, full_o && empty};

  DepthBound_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= CntW'(Depth));

endmodule

// ==== hw/drbg_pkg.sv ====
// --------------------------------------------------------------------------
// DRBG command stage package.
// Command opcodes, field positions and word types shared by the stage.
// --------------------------------------------------------------------------

package drbg_pkg;

  // Command word layout.
  localparam int unsigned CmdWidth     = 32;
  localparam int unsigned OpWidth      = 3;
  localparam int unsigned ClenLsb      = 4;
  localparam int unsigned ClenWidth    = 4;
  localparam int unsigned GlenLsb      = 12;
  localparam int unsigned GlenWidth    = 12;
  // Opcode, clen and flags, replayed for each generate block.
  localparam int unsigned CmdKeepWidth = 12;

  typedef enum logic [OpWidth-1:0] {
    INS = 3'd1,
    RES = 3'd2,
    GEN = 3'd3,
    UPD = 3'd4,
    UNI = 3'd5
  } acmd_e;

  typedef logic [CmdWidth-1:0]     cmd_word_t;
  typedef logic [ClenWidth-1:0]    clen_t;
  typedef logic [GlenWidth-1:0]    glen_t;
  typedef logic [CmdKeepWidth-1:0] cmd_keep_t;
  typedef logic [127:0]            genbits_t;

  // {write when full, read when empty, full while empty}.
  typedef logic [2:0]              fifo_err_t;

endpackage
